// File: project.f
hdl/cpuPkg.sv
hdl/pipeBus.sv
hdl/stageFetch.sv
hdl/stageDecode.sv
hdl/stageExecute.sv
hdl/stageMemory.sv
hdl/cpuPipe.sv
tb/cpuPipeTb.sv

// File: Bender.yml
package:
  name: cpuPipe

sources:
  - hdl/cpuPkg.sv
  - hdl/pipeBus.sv
  - hdl/stageFetch.sv
  - hdl/stageDecode.sv
  - hdl/stageExecute.sv
  - hdl/stageMemory.sv
  - hdl/cpuPipe.sv
  - target: test
    files:
      - tb/cpuPipeTb.sv

// File: tb/cpuPipeTb.sv
// pipeline core testbench
`default_nettype none

module cpuPipeTb;

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 8;
    localparam int IDLE_CYCLES = 10;
    localparam int DRAIN_CYCLES = 8;
    // half a cycle to the first sampled edge plus four register stages
    localparam int FIRST_WB_NEG = 5;

    typedef struct packed {
        logic [cpuPkg::REG_IDX_W-1:0] rd;
        logic [cpuPkg::XLEN-1:0] data;
    } wbEventT;

    typedef struct packed {
        logic [cpuPkg::XLEN-1:0] addr;
        logic [cpuPkg::XLEN-1:0] data;
    } storeEventT;

    logic clk;
    logic arstN;
    logic run;
    logic imemWe;
    logic [cpuPkg::XLEN-1:0] imemAddr;
    logic [cpuPkg::XLEN-1:0] imemWdata;
    logic wbValid;
    logic [cpuPkg::REG_IDX_W-1:0] wbRd;
    logic [cpuPkg::XLEN-1:0] wbData;
    logic dmemWe;
    logic [cpuPkg::XLEN-1:0] dmemAddr;
    logic [cpuPkg::XLEN-1:0] dmemWdata;

    logic [31:0] lcgState;
    logic [31:0] prog [$];
    logic [31:0] progIdle [$];
    logic [31:0] progAlu [$];
    logic [31:0] progZero [$];
    logic [31:0] progMem [$];
    logic [31:0] progBranch [$];
    logic [cpuPkg::XLEN-1:0] modelRegs [cpuPkg::REG_COUNT];
    logic [cpuPkg::XLEN-1:0] modelMem [cpuPkg::DMEM_DEPTH];
    wbEventT expWb [$];
    storeEventT expStore [$];
    wbEventT wbExp;
    storeEventT storeExp;
    int negCount = 0;
    int firstWbNeg = -1;
    int budgetCycles = 0;
    logic budgetReady = 1'b0;

    cpuPipe DUT (
        .clk       (clk),
        .arstN     (arstN),
        .run       (run),
        .imemWe    (imemWe),
        .imemAddr  (imemAddr),
        .imemWdata (imemWdata),
        .wbValid   (wbValid),
        .wbRd      (wbRd),
        .wbData    (wbData),
        .dmemWe    (dmemWe),
        .dmemAddr  (dmemAddr),
        .dmemWdata (dmemWdata)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic stopWithFail();
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkWb(input logic [cpuPkg::REG_IDX_W-1:0] gotRd,
                           input logic [cpuPkg::XLEN-1:0] gotData,
                           input logic [cpuPkg::REG_IDX_W-1:0] expRd,
                           input logic [cpuPkg::XLEN-1:0] expData);
        if (gotRd !== expRd || gotData !== expData) begin
            $display("ERROR %0t: writeback x%0d = %h, expected x%0d = %h",
                     $time, gotRd, gotData, expRd, expData);
            stopWithFail();
        end
    endtask

    task automatic checkStore(input logic [cpuPkg::XLEN-1:0] gotAddr,
                              input logic [cpuPkg::XLEN-1:0] gotData,
                              input logic [cpuPkg::XLEN-1:0] expAddr,
                              input logic [cpuPkg::XLEN-1:0] expData);
        if (gotAddr !== expAddr || gotData !== expData) begin
            $display("ERROR %0t: store [%h] = %h, expected [%h] = %h",
                     $time, gotAddr, gotData, expAddr, expData);
            stopWithFail();
        end
    endtask

    task automatic checkLatency(input int got, input int exp);
        if (got != exp) begin
            $display("ERROR %0t: first writeback after %0d falling edges, expected %0d",
                     $time, got, exp);
            stopWithFail();
        end
    endtask

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [11:0] randImm();
        lcgState = lcgNext(lcgState);
        return lcgState[27:16];
    endfunction

    // instruction encoders
    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, cpuPkg::OP_REG};
    endfunction

    function automatic logic [31:0] encAddi(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, cpuPkg::OP_IMM};
    endfunction

    function automatic logic [31:0] encLw(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, cpuPkg::OP_LOAD};
    endfunction

    function automatic logic [31:0] encSw(input logic [4:0] rs2, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], cpuPkg::OP_STORE};
    endfunction

    function automatic logic [31:0] encBranch(input logic [2:0] f3, input logic [4:0] rs1,
                                              input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], cpuPkg::OP_BRANCH};
    endfunction

    // reference model for one instruction in program order
    task automatic modelStep(input logic [31:0] word, input logic [31:0] pc,
                             output logic taken, output logic [31:0] target);
        logic [2:0] f3;
        logic [4:0] rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] res;
        logic writes;
        f3 = word[14:12];
        rd = word[11:7];
        a = (word[19:15] == '0) ? '0 : modelRegs[word[19:15]];
        b = (word[24:20] == '0) ? '0 : modelRegs[word[24:20]];
        taken = 1'b0;
        target = pc + {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
        writes = 1'b0;
        res = '0;
        case (word[6:0])
            cpuPkg::OP_REG: begin
                writes = 1'b1;
                case (f3)
                    3'b000: res = (word[31:25] == 7'b0100000) ? a - b : a + b;
                    3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'b100: res = a ^ b;
                    3'b110: res = a | b;
                    3'b111: res = a & b;
                    default: res = a + b;
                endcase
            end
            cpuPkg::OP_IMM: begin
                writes = 1'b1;
                res = a + {{20{word[31]}}, word[31:20]};
            end
            cpuPkg::OP_LOAD: begin
                writes = 1'b1;
                addr = a + {{20{word[31]}}, word[31:20]};
                res = modelMem[addr[cpuPkg::DMEM_IDX_W+1:2]];
            end
            cpuPkg::OP_STORE: begin
                addr = a + {{20{word[31]}}, word[31:25], word[11:7]};
                modelMem[addr[cpuPkg::DMEM_IDX_W+1:2]] = b;
                expStore.push_back(storeEventT'{addr: addr, data: b});
            end
            cpuPkg::OP_BRANCH: begin
                if (f3 == 3'b000) begin
                    taken = (a == b);
                end else if (f3 == 3'b001) begin
                    taken = (a != b);
                end
            end
            default: ;
        endcase
        if (writes && rd != '0) begin
            modelRegs[rd] = res;
            expWb.push_back(wbEventT'{rd: rd, data: res});
        end
    endtask

    // walks the fetch order with three delay slots and returns the fetch count
    task automatic modelProgram(output int fetches);
        logic [31:0] pc;
        logic [31:0] target;
        logic [31:0] pendingPc;
        logic [31:0] word;
        logic taken;
        int redirectAt;
        pc = '0;
        pendingPc = '0;
        redirectAt = -1;
        fetches = 0;
        while ((pc < prog.size() * 4 || redirectAt >= fetches)
               && fetches < cpuPkg::IMEM_DEPTH) begin
            word = (pc / 4 < prog.size()) ? prog[pc / 4] : '0;
            modelStep(word, pc, taken, target);
            if (taken) begin
                redirectAt = fetches + 3;
                pendingPc = target;
            end
            pc = (fetches == redirectAt) ? pendingPc : pc + 32'd4;
            fetches++;
        end
    endtask

    task automatic stepCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic applyReset();
        arstN = 1'b0;
        run = 1'b0;
        imemWe = 1'b0;
        repeat (RESET_CYCLES) stepCycle();
        arstN = 1'b1;
        for (int i = 0; i < cpuPkg::REG_COUNT; i++) begin
            modelRegs[i] = '0;
        end
    endtask

    task automatic runProgram(input int idleCycles, output int latency);
        int fetches;
        int runNeg;
        applyReset();
        for (int i = 0; i < cpuPkg::IMEM_DEPTH; i++) begin
            imemWe = 1'b1;
            imemAddr = 32'(i * 4);
            imemWdata = (i < prog.size()) ? prog[i] : '0;
            stepCycle();
        end
        imemWe = 1'b0;
        // run stays low here so no event may appear
        repeat (idleCycles) stepCycle();
        modelProgram(fetches);
        firstWbNeg = -1;
        runNeg = negCount;
        run = 1'b1;
        repeat (fetches) stepCycle();
        run = 1'b0;
        while (expWb.size() != 0 || expStore.size() != 0) begin
            stepCycle();
        end
        repeat (DRAIN_CYCLES) stepCycle();
        latency = firstWbNeg - runNeg;
    endtask

    task automatic buildPrograms();
        logic [11:0] imm;
        progIdle = {encAddi(5'd1, 5'd0, 12'd42), encAddi(5'd2, 5'd0, 12'hfff)};
        progAlu = {};
        for (int r = 1; r <= 4; r++) begin
            imm = randImm();
            // x1 kept positive and x4 negative so slt sees mixed signs
            if (r == 1) begin
                imm[11] = 1'b0;
            end else if (r == 4) begin
                imm[11] = 1'b1;
            end
            progAlu.push_back(encAddi(5'(r), 5'd0, imm));
        end
        progAlu.push_back(encR(7'b0, cpuPkg::F3_ADD_SUB, 5'd5, 5'd1, 5'd2));
        progAlu.push_back(encR(cpuPkg::F7_SUB, cpuPkg::F3_ADD_SUB, 5'd6, 5'd1, 5'd2));
        progAlu.push_back(encR(7'b0, cpuPkg::F3_AND, 5'd7, 5'd3, 5'd4));
        progAlu.push_back(encR(7'b0, cpuPkg::F3_OR, 5'd8, 5'd3, 5'd4));
        progAlu.push_back(encR(7'b0, cpuPkg::F3_XOR, 5'd9, 5'd1, 5'd3));
        progAlu.push_back(encR(7'b0, cpuPkg::F3_SLT, 5'd10, 5'd1, 5'd2));
        progAlu.push_back(encR(7'b0, cpuPkg::F3_SLT, 5'd11, 5'd4, 5'd1));
        progAlu.push_back(encAddi(5'd12, 5'd5, randImm()));
        progZero = {encAddi(5'd0, 5'd0, 12'd123), encAddi(5'd1, 5'd0, 12'd77),
                    encR(7'b0, cpuPkg::F3_XOR, 5'd0, 5'd3, 5'd3),
                    encAddi(5'd2, 5'd0, 12'd5),
                    encR(7'b0, cpuPkg::F3_ADD_SUB, 5'd3, 5'd0, 5'd1),
                    encR(7'b0, cpuPkg::F3_OR, 5'd4, 5'd0, 5'd0)};
        progMem = {encAddi(5'd1, 5'd0, 12'd64), encAddi(5'd2, 5'd0, -12'sd300),
                   encAddi(5'd3, 5'd0, 12'h123), encAddi(5'd4, 5'd0, 12'd4),
                   encSw(5'd2, 5'd1, 12'd8), encSw(5'd3, 5'd1, -12'sd4),
                   encLw(5'd5, 5'd1, 12'd8), encLw(5'd6, 5'd1, -12'sd4),
                   encAddi(5'd7, 5'd0, 12'd1), encAddi(5'd9, 5'd0, 12'd2),
                   encR(7'b0, cpuPkg::F3_ADD_SUB, 5'd8, 5'd5, 5'd6)};
        // beq at word 4 jumps to word 10 past words 8 and 9
        // a taken bne at word 10 would skip word 14
        progBranch = {encAddi(5'd1, 5'd0, 12'd5), encAddi(5'd2, 5'd0, 12'd5),
                      encAddi(5'd3, 5'd0, 12'd7), encAddi(5'd4, 5'd0, 12'd1),
                      encBranch(cpuPkg::F3_BEQ, 5'd1, 5'd2, 13'd24),
                      encAddi(5'd5, 5'd0, 12'd11), encAddi(5'd6, 5'd0, 12'd12),
                      encAddi(5'd7, 5'd0, 12'd13), encAddi(5'd8, 5'd0, 12'd99),
                      encAddi(5'd9, 5'd0, 12'd98),
                      encBranch(cpuPkg::F3_BNE, 5'd1, 5'd2, 13'd20),
                      encAddi(5'd10, 5'd0, 12'd21), encAddi(5'd11, 5'd0, 12'd22),
                      encAddi(5'd12, 5'd0, 12'd23),
                      encR(7'b0, cpuPkg::F3_ADD_SUB, 5'd13, 5'd3, 5'd4),
                      encAddi(5'd14, 5'd0, 12'd31)};
    endtask

    function automatic int testBudget(input int words);
        return words + 20 + RESET_CYCLES + cpuPkg::IMEM_DEPTH + IDLE_CYCLES + DRAIN_CYCLES;
    endfunction

    task automatic testIdleLatency();
        int latency;
        $display("test: idle and first writeback latency");
        prog = progIdle;
        runProgram(IDLE_CYCLES, latency);
        checkLatency(latency, FIRST_WB_NEG);
    endtask

    task automatic testAlu();
        int latency;
        $display("test: alu operations");
        prog = progAlu;
        runProgram(0, latency);
    endtask

    task automatic testRegZero();
        int latency;
        $display("test: register zero");
        prog = progZero;
        runProgram(0, latency);
    endtask

    task automatic testStoreLoad();
        int latency;
        $display("test: stores and loads");
        prog = progMem;
        runProgram(0, latency);
    endtask

    task automatic testBranch();
        int latency;
        $display("test: branches and delay slots");
        prog = progBranch;
        runProgram(0, latency);
    endtask

    // writeback monitor samples mid cycle
    always @(negedge clk) begin
        negCount = negCount + 1;
        if (arstN && wbValid) begin
            if (firstWbNeg < 0) begin
                firstWbNeg = negCount;
            end
            if (expWb.size() == 0) begin
                $display("unexpected writeback to x%0d at time %0t", wbRd, $time);
                stopWithFail();
            end else begin
                wbExp = expWb.pop_front();
                checkWb(wbRd, wbData, wbExp.rd, wbExp.data);
            end
        end
    end

    // store monitor
    always @(negedge clk) begin
        if (arstN && dmemWe) begin
            if (expStore.size() == 0) begin
                $display("unexpected store to %h at time %0t", dmemAddr, $time);
                stopWithFail();
            end else begin
                storeExp = expStore.pop_front();
                checkStore(dmemAddr, dmemWdata, storeExp.addr, storeExp.data);
            end
        end
    end

    initial begin
        wait (budgetReady);
        #(budgetCycles * CLK_PERIOD);
        $display("timeout: tests still running after %0d cycles", budgetCycles);
        stopWithFail();
    end

    initial begin
        arstN = 1'b0;
        run = 1'b0;
        imemWe = 1'b0;
        imemAddr = '0;
        imemWdata = '0;
        lcgState = 32'd31;
        buildPrograms();
        budgetCycles = testBudget(progIdle.size()) + testBudget(progAlu.size())
                     + testBudget(progZero.size()) + testBudget(progMem.size())
                     + testBudget(progBranch.size());
        budgetReady = 1'b1;
        testIdleLatency();
        testAlu();
        testRegZero();
        testStoreLoad();
        testBranch();
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/cpuPipe.sv
// five-stage rv32i pipeline
`default_nettype none

module cpuPipe (
    input  wire                             clk,
    input  wire                             arstN,
    input  wire                             run,
    input  wire                             imemWe,
    input  wire  [cpuPkg::XLEN-1:0]         imemAddr,
    input  wire  [cpuPkg::XLEN-1:0]         imemWdata,
    output logic                            wbValid,
    output logic [cpuPkg::REG_IDX_W-1:0]    wbRd,
    output logic [cpuPkg::XLEN-1:0]         wbData,
    output logic                            dmemWe,
    output logic [cpuPkg::XLEN-1:0]         dmemAddr,
    output logic [cpuPkg::XLEN-1:0]         dmemWdata
);

    logic                       fdValid;
    logic [cpuPkg::XLEN-1:0]    fdPc;
    logic [cpuPkg::XLEN-1:0]    fdInstr;
    logic                       redirect;
    logic [cpuPkg::XLEN-1:0]    redirectPc;

    idExBus idEx ();
    exMemBus exMem ();
    memWbBus memWb ();

    stageFetch uFetch (
        .clk        (clk),
        .arstN      (arstN),
        .run        (run),
        .imemWe     (imemWe),
        .imemAddr   (imemAddr),
        .imemWdata  (imemWdata),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .fdValid    (fdValid),
        .fdPc       (fdPc),
        .fdInstr    (fdInstr)
    );

    stageDecode uDecode (
        .clk     (clk),
        .arstN   (arstN),
        .fdValid (fdValid),
        .fdPc    (fdPc),
        .fdInstr (fdInstr),
        .wb      (memWb.dst),
        .idEx    (idEx.src)
    );

    stageExecute uExecute (
        .clk   (clk),
        .arstN (arstN),
        .idEx  (idEx.dst),
        .exMem (exMem.src)
    );

    stageMemory uMemory (
        .clk        (clk),
        .arstN      (arstN),
        .exMem      (exMem.dst),
        .memWb      (memWb.src),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .dmemWe     (dmemWe),
        .dmemAddr   (dmemAddr),
        .dmemWdata  (dmemWdata)
    );

    // stores, branches and x0 writes show no writeback event
    assign wbValid = memWb.valid && memWb.regWrite;
    assign wbRd = memWb.rd;
    assign wbData = memWb.data;

endmodule

`default_nettype wire

// File: hdl/stageMemory.sv
// memory access stage
`default_nettype none

module stageMemory (
    input  wire                         clk,
    input  wire                         arstN,
    exMemBus.dst                        exMem,
    memWbBus.src                        memWb,
    output logic                        redirect,
    output logic [cpuPkg::XLEN-1:0]     redirectPc,
    output logic                        dmemWe,
    output logic [cpuPkg::XLEN-1:0]     dmemAddr,
    output logic [cpuPkg::XLEN-1:0]     dmemWdata
);

    logic [cpuPkg::XLEN-1:0]        dmem [cpuPkg::DMEM_DEPTH];
    logic [cpuPkg::DMEM_IDX_W-1:0]  wordIdx;
    logic [cpuPkg::XLEN-1:0]        wbData;

    assign wordIdx = exMem.aluResult[cpuPkg::DMEM_IDX_W+1:2];

    assign dmemWe = exMem.valid && exMem.ctrl.memWrite;
    assign dmemAddr = exMem.aluResult;
    assign dmemWdata = exMem.storeData;

    always_ff @(posedge clk) begin
        if (dmemWe) begin
            dmem[wordIdx] <= exMem.storeData;
        end
    end

    // load data or alu result into writeback
    assign wbData = exMem.ctrl.memToReg ? dmem[wordIdx] : exMem.aluResult;

    assign redirect = exMem.valid && exMem.ctrl.branch && exMem.branchCond;
    assign redirectPc = exMem.branchTarget;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            memWb.valid <= 1'b0;
            memWb.regWrite <= 1'b0;
        end else begin
            memWb.valid <= exMem.valid;
            memWb.regWrite <= exMem.valid && exMem.ctrl.regWrite && exMem.rd != '0;
        end
    end

    always_ff @(posedge clk) begin
        memWb.rd <= exMem.rd;
        memWb.data <= wbData;
    end

    // decode never sets both for one instruction
    aLoadStoreExcl: assert property (
        @(posedge clk) disable iff (!arstN)
        exMem.valid |-> !(exMem.ctrl.memRead && exMem.ctrl.memWrite)
    );

endmodule

`default_nettype wire

// File: hdl/stageExecute.sv
// execute stage
`default_nettype none

module stageExecute (
    input  wire     clk,
    input  wire     arstN,
    idExBus.dst     idEx,
    exMemBus.src    exMem
);

    logic [cpuPkg::XLEN-1:0] opB;
    logic [cpuPkg::XLEN-1:0] aluResult;
    logic [cpuPkg::XLEN-1:0] branchTarget;
    logic                    lessThan;
    logic                    branchCond;

    assign opB = idEx.ctrl.aluSrc ? idEx.imm : idEx.rs2Val;
    assign lessThan = $signed(idEx.rs1Val) < $signed(opB);

    always_comb begin
        case (idEx.aluOp)
            cpuPkg::ALU_ADD: aluResult = idEx.rs1Val + opB;
            cpuPkg::ALU_SUB: aluResult = idEx.rs1Val - opB;
            cpuPkg::ALU_AND: aluResult = idEx.rs1Val & opB;
            cpuPkg::ALU_OR: aluResult = idEx.rs1Val | opB;
            cpuPkg::ALU_XOR: aluResult = idEx.rs1Val ^ opB;
            cpuPkg::ALU_SLT: aluResult = {{(cpuPkg::XLEN-1){1'b0}}, lessThan};
            default: aluResult = idEx.rs1Val + opB;
        endcase
    end

    // branch compares the register values, not the alu operand
    assign branchTarget = idEx.pc + idEx.imm;
    assign branchCond = idEx.ctrl.branchNe ? (idEx.rs1Val != idEx.rs2Val)
                                           : (idEx.rs1Val == idEx.rs2Val);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exMem.valid <= 1'b0;
        end else begin
            exMem.valid <= idEx.valid;
        end
    end

    always_ff @(posedge clk) begin
        exMem.aluResult <= aluResult;
        exMem.storeData <= idEx.rs2Val;
        exMem.branchTarget <= branchTarget;
        exMem.branchCond <= branchCond;
        exMem.rd <= idEx.rd;
        exMem.ctrl <= idEx.ctrl;
    end

endmodule

`default_nettype wire

// File: hdl/stageDecode.sv
// instruction decode stage
`default_nettype none

module stageDecode (
    input  wire                         clk,
    input  wire                         arstN,
    input  wire                         fdValid,
    input  wire  [cpuPkg::XLEN-1:0]     fdPc,
    input  wire  [cpuPkg::XLEN-1:0]     fdInstr,
    memWbBus.dst                        wb,
    idExBus.src                         idEx
);

    logic [cpuPkg::XLEN-1:0]        regs [cpuPkg::REG_COUNT];
    cpuPkg::opcodeE                 opcode;
    logic [2:0]                     funct3;
    logic [6:0]                     funct7;
    logic [cpuPkg::REG_IDX_W-1:0]   rs1;
    logic [cpuPkg::REG_IDX_W-1:0]   rs2;
    logic [cpuPkg::XLEN-1:0]        immI;
    logic [cpuPkg::XLEN-1:0]        immS;
    logic [cpuPkg::XLEN-1:0]        immB;
    logic [cpuPkg::XLEN-1:0]        imm;
    logic                           known;
    logic                           wbWe;
    cpuPkg::aluOpE                  regAluOp;
    cpuPkg::aluOpE                  aluOp;
    cpuPkg::ctrlWordT               ctrl;

    assign opcode = cpuPkg::opcodeE'(fdInstr[6:0]);
    assign funct3 = fdInstr[14:12];
    assign funct7 = fdInstr[31:25];
    assign rs1 = fdInstr[19:15];
    assign rs2 = fdInstr[24:20];

    assign immI = {{20{fdInstr[31]}}, fdInstr[31:20]};
    assign immS = {{20{fdInstr[31]}}, fdInstr[31:25], fdInstr[11:7]};
    assign immB = {{19{fdInstr[31]}}, fdInstr[31], fdInstr[7], fdInstr[30:25],
                   fdInstr[11:8], 1'b0};

    assign wbWe = wb.valid && wb.regWrite;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < cpuPkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wbWe) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // write-through so writeback and decode can share a cycle
    function automatic logic [cpuPkg::XLEN-1:0] readReg(
        input logic [cpuPkg::REG_IDX_W-1:0] idx
    );
        if (idx == '0) begin
            return '0;
        end
        if (wbWe && wb.rd == idx) begin
            return wb.data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        case (funct3)
            cpuPkg::F3_ADD_SUB: regAluOp = (funct7 == cpuPkg::F7_SUB) ? cpuPkg::ALU_SUB
                                                                       : cpuPkg::ALU_ADD;
            cpuPkg::F3_SLT: regAluOp = cpuPkg::ALU_SLT;
            cpuPkg::F3_XOR: regAluOp = cpuPkg::ALU_XOR;
            cpuPkg::F3_OR: regAluOp = cpuPkg::ALU_OR;
            cpuPkg::F3_AND: regAluOp = cpuPkg::ALU_AND;
            default: regAluOp = cpuPkg::ALU_ADD;
        endcase
    end

    always_comb begin
        ctrl = '0;
        aluOp = cpuPkg::ALU_ADD;
        imm = immI;
        known = 1'b1;
        case (opcode)
            cpuPkg::OP_REG: begin
                ctrl.regWrite = 1'b1;
                aluOp = regAluOp;
            end
            cpuPkg::OP_IMM: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
            end
            cpuPkg::OP_LOAD: begin
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.aluSrc = 1'b1;
            end
            cpuPkg::OP_STORE: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
                imm = immS;
            end
            cpuPkg::OP_BRANCH: begin
                ctrl.branch = 1'b1;
                ctrl.branchNe = (funct3 == cpuPkg::F3_BNE);
                imm = immB;
                // only beq and bne are supported
                known = (funct3 == cpuPkg::F3_BEQ) || (funct3 == cpuPkg::F3_BNE);
            end
            default: known = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            idEx.valid <= 1'b0;
        end else begin
            idEx.valid <= fdValid && known;
        end
    end

    always_ff @(posedge clk) begin
        idEx.pc <= fdPc;
        idEx.rs1Val <= readReg(rs1);
        idEx.rs2Val <= readReg(rs2);
        idEx.imm <= imm;
        idEx.rd <= fdInstr[11:7];
        idEx.aluOp <= aluOp;
        idEx.ctrl <= ctrl;
    end

    // memory stage must drop regWrite for x0
    aNoWriteX0: assert property (
        @(posedge clk) disable iff (!arstN) wbWe |-> wb.rd != '0
    );

endmodule

`default_nettype wire

// File: hdl/stageFetch.sv
// instruction fetch stage
`default_nettype none

module stageFetch (
    input  wire                         clk,
    input  wire                         arstN,
    input  wire                         run,
    input  wire                         imemWe,
    input  wire  [cpuPkg::XLEN-1:0]     imemAddr,
    input  wire  [cpuPkg::XLEN-1:0]     imemWdata,
    input  wire                         redirect,
    input  wire  [cpuPkg::XLEN-1:0]     redirectPc,
    output logic                        fdValid,
    output logic [cpuPkg::XLEN-1:0]     fdPc,
    output logic [cpuPkg::XLEN-1:0]     fdInstr
);

    logic [cpuPkg::XLEN-1:0] imem [cpuPkg::IMEM_DEPTH];
    logic [cpuPkg::XLEN-1:0] pc;
    logic [cpuPkg::XLEN-1:0] pcNext;

    // load port takes a byte address, like the pc
    always_ff @(posedge clk) begin
        if (imemWe) begin
            imem[imemAddr[cpuPkg::IMEM_IDX_W+1:2]] <= imemWdata;
        end
    end

    assign pcNext = (redirect ? redirectPc : pc + 32'd4) & cpuPkg::PC_MASK;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
            fdValid <= 1'b0;
        end else begin
            fdValid <= run;
            if (run) begin
                pc <= pcNext;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (run) begin
            fdPc <= pc;
            fdInstr <= imem[pc[cpuPkg::IMEM_IDX_W+1:2]];
        end
    end

    // branch targets come from the memory stage
    aRedirectAligned: assert property (
        @(posedge clk) disable iff (!arstN) redirect |-> redirectPc[1:0] == 2'b00
    );

endmodule

`default_nettype wire

// File: hdl/pipeBus.sv
// pipeline stage buses
`default_nettype none

interface idExBus;
    logic                           valid;
    logic [cpuPkg::XLEN-1:0]        pc;
    logic [cpuPkg::XLEN-1:0]        rs1Val;
    logic [cpuPkg::XLEN-1:0]        rs2Val;
    logic [cpuPkg::XLEN-1:0]        imm;
    logic [cpuPkg::REG_IDX_W-1:0]   rd;
    cpuPkg::aluOpE                  aluOp;
    cpuPkg::ctrlWordT               ctrl;

    modport src (output valid, pc, rs1Val, rs2Val, imm, rd, aluOp, ctrl);
    modport dst (input valid, pc, rs1Val, rs2Val, imm, rd, aluOp, ctrl);
endinterface

interface exMemBus;
    logic                           valid;
    logic [cpuPkg::XLEN-1:0]        aluResult;
    logic [cpuPkg::XLEN-1:0]        storeData;
    logic [cpuPkg::XLEN-1:0]        branchTarget;
    logic                           branchCond;
    logic [cpuPkg::REG_IDX_W-1:0]   rd;
    cpuPkg::ctrlWordT               ctrl;

    modport src (output valid, aluResult, storeData, branchTarget, branchCond, rd, ctrl);
    modport dst (input valid, aluResult, storeData, branchTarget, branchCond, rd, ctrl);
endinterface

interface memWbBus;
    logic                           valid;
    logic                           regWrite;
    logic [cpuPkg::REG_IDX_W-1:0]   rd;
    logic [cpuPkg::XLEN-1:0]        data;

    modport src (output valid, regWrite, rd, data);
    modport dst (input valid, regWrite, rd, data);
endinterface

`default_nettype wire

// File: hdl/cpuPkg.sv
// cpu shared definitions
`default_nettype none

package cpuPkg;

    localparam int XLEN = 32;
    localparam int REG_COUNT = 32;
    localparam int REG_IDX_W = 5;

    localparam int IMEM_DEPTH = 64;
    localparam int IMEM_IDX_W = $clog2(IMEM_DEPTH);
    localparam int DMEM_DEPTH = 64;
    localparam int DMEM_IDX_W = $clog2(DMEM_DEPTH);

    // byte mask that keeps the pc inside instruction memory
    localparam logic [XLEN-1:0] PC_MASK = IMEM_DEPTH * 4 - 1;

    // funct3 / funct7 codes
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [6:0] F7_SUB = 7'b0100000;

    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011
    } opcodeE;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } aluOpE;

    typedef struct packed {
        logic regWrite;
        logic memToReg;
        logic memRead;
        logic memWrite;
        logic branch;
        logic branchNe;
        logic aluSrc;
    } ctrlWordT;

endpackage

`default_nettype wire
